// File: tb.f
+incdir+include
verilog/isa_pkg.sv
verilog/pipe_pkg.sv
verilog/pipe_if.sv
verilog/reg_file.sv
verilog/decode_stage.sv
verilog/alu.sv
verilog/execute_stage.sv
verilog/result_stage.sv
verilog/rv_core_top.sv
tb/tb_clock.sv
tb/tb_core.sv

// File: tb/tb_core.sv
`include "rv_defs.svh"

module tb_core;
    import isa_pkg::*;

    localparam int RST_CYCLES  = 16;
    localparam int MAX_SLOTS   = 800;                // Bound on accepted slots over all tests
    localparam int STALL_MAX   = 4;                  // Longest stall span
    localparam int STIM_CYCLES = RST_CYCLES + MAX_SLOTS * (STALL_MAX + 1);
    localparam int LIMIT       = STIM_CYCLES + 50;

    typedef struct packed {
        logic [31:0] due;  // Unstalled edge where the pulse is sampled
        logic [4:0]  rd;
        logic [31:0] data;
    } wb_ev_t;

    typedef struct packed {
        logic [31:0] due;
        logic        taken;
        logic [31:0] target;
    } br_ev_t;

    logic        clk;
    logic        rst;
    logic        stall;
    logic        instr_valid;
    logic [31:0] instr;
    logic [31:0] pc;
    logic        wb_valid;
    logic [4:0]  wb_rd;
    logic [31:0] wb_data;
    logic        br_valid;
    logic        br_taken;
    logic [31:0] br_target;

    logic [31:0] rf [`RV_NREGS];  // Reference register file
    wb_ev_t      wb_q [$];
    br_ev_t      br_q [$];
    wb_ev_t      wb_head;
    br_ev_t      br_head;
    logic [31:0] pc_r;            // PC of the next issued word
    logic [31:0] pa [4];          // Branch operand pairs
    logic [31:0] pb [4];
    logic [11:0] imm_set [6];
    logic [12:0] boff;
    logic        stall_on;
    logic        exp_wb;
    logic        exp_br;
    int          stall_left;
    int          adv;             // Count of unstalled edges after reset
    int          edge_n;
    int          cycles;
    int          val_errs;
    int          pulse_errs;
    int          seed;

    tb_clock u_clk (.clk(clk));

    rv_core_top uut (
        .clk         (clk),
        .rst         (rst),
        .stall       (stall),
        .instr_valid (instr_valid),
        .instr       (instr),
        .pc          (pc),
        .wb_valid    (wb_valid),
        .wb_rd       (wb_rd),
        .wb_data     (wb_data),
        .br_valid    (br_valid),
        .br_taken    (br_taken),
        .br_target   (br_target)
    );

    // RV32I arithmetic rule, alt is instruction bit 30
    function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return {31'd0, $signed(a) < $signed(b)};
            3'd3:    return {31'd0, a < b};
            3'd4:    return a ^ b;
            3'd5:    return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic br_ref(input logic [2:0] f3, input logic [31:0] a,
                                    input logic [31:0] b);
        case (f3)
            3'd0:    return a == b;
            3'd1:    return a != b;
            3'd4:    return $signed(a) < $signed(b);
            3'd5:    return $signed(a) >= $signed(b);
            3'd6:    return a < b;
            default: return a >= b;
        endcase
    endfunction

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        instr_u w;
        w.r = '{f7, rs2, rs1, f3, rd, OPC_OP};
        return w;
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input opcode_e opc);
        instr_u w;
        w.i = '{imm, rs1, f3, rd, opc};
        return w;
    endfunction

    function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                          input opcode_e opc);
        instr_u w;
        w.u = '{imm, rd, opc};
        return w;
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] off, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        instr_u w;
        w.b = '{off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
        return w;
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] off, input logic [4:0] rd);
        instr_u w;
        w.j = '{off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
        return w;
    endfunction

    // Drive one word on the falling edge until an unstalled edge takes it
    task automatic issue(input logic [31:0] word, output int acc_edge);
        logic done;
        done = 1'b0;
        while (!done)
        begin
            @(negedge clk);
            instr_valid = 1'b1;
            instr       = word;
            pc          = pc_r;
            acc_edge    = adv + 1;   // Number of the coming edge if it advances
            @(posedge clk);
            done = !stall;
        end
        pc_r = pc_r + 32'd4;
    endtask

    // Issue, queue the expected events, then two NOPs for dependency spacing
    task automatic send(input logic [31:0] word, input logic wb_en, input logic [4:0] rd,
                        input logic [31:0] data, input logic br_en, input logic taken,
                        input logic [31:0] target);
        int a;
        issue(word, a);
        if (wb_en && (rd != 5'd0))
        begin
            wb_q.push_back('{a + 3, rd, data});
            rf[rd] = data;
        end
        if (br_en)
            br_q.push_back('{a + 2, taken, target});
        issue(`RV_NOP, a);
        issue(`RV_NOP, a);
    endtask

    task automatic do_rr(input logic [2:0] f3, input logic alt, input logic [4:0] rd,
                         input logic [4:0] rs1, input logic [4:0] rs2);
        send(enc_r(alt ? 7'h20 : 7'h00, rs2, rs1, f3, rd), 1'b1, rd,
             alu_ref(f3, alt, rf[rs1], rf[rs2]), 1'b0, 1'b0, 32'd0);
    endtask

    task automatic do_imm(input logic [2:0] f3, input logic [4:0] rd, input logic [4:0] rs1,
                          input logic [11:0] imm);
        logic alt;
        alt = (f3 == 3'd5) && imm[10];    // SRAI only
        send(enc_i(imm, rs1, f3, rd, OPC_OP_IMM), 1'b1, rd,
             alu_ref(f3, alt, rf[rs1], {{20{imm[11]}}, imm}), 1'b0, 1'b0, 32'd0);
    endtask

    task automatic do_lui(input logic [4:0] rd, input logic [19:0] u);
        send(enc_u(u, rd, OPC_LUI), 1'b1, rd, {u, 12'd0}, 1'b0, 1'b0, 32'd0);
    endtask

    task automatic do_auipc(input logic [4:0] rd, input logic [19:0] u);
        send(enc_u(u, rd, OPC_AUIPC), 1'b1, rd, pc_r + {u, 12'd0}, 1'b0, 1'b0, 32'd0);
    endtask

    task automatic do_br(input logic [2:0] f3, input logic [4:0] rs1, input logic [4:0] rs2,
                         input logic [12:0] off);
        logic [31:0] tgt;
        tgt = pc_r + {{19{off[12]}}, off};
        send(enc_b(off, rs2, rs1, f3), 1'b0, 5'd0, 32'd0, 1'b1,
             br_ref(f3, rf[rs1], rf[rs2]), tgt);
    endtask

    task automatic do_jal(input logic [4:0] rd, input logic [20:0] off);
        logic [31:0] tgt;
        tgt = pc_r + {{11{off[20]}}, off};
        send(enc_j(off, rd), 1'b1, rd, pc_r + 32'd4, 1'b1, 1'b1, tgt);
    endtask

    task automatic do_jalr(input logic [4:0] rd, input logic [4:0] rs1, input logic [11:0] imm);
        logic [31:0] sum;
        sum = rf[rs1] + {{20{imm[11]}}, imm};  // Old rs1, even when rd equals rs1
        send(enc_i(imm, rs1, 3'd0, rd, OPC_JALR), 1'b1, rd, pc_r + 32'd4, 1'b1, 1'b1,
             {sum[31:1], 1'b0});
    endtask

    // LUI rounds up so the signed ADDI low part lands on v
    task automatic load(input logic [4:0] rd, input logic [31:0] v);
        logic [31:0] hi;
        hi = v + 32'h800;
        do_lui(rd, hi[31:12]);
        do_imm(3'd0, rd, rd, v[11:0]);
    endtask

    task automatic report_value(input string name, input logic [31:0] exp,
                                input logic [31:0] got);
        val_errs++;
        $display("FAIL %s: expected %h, got %h at edge %0d", name, exp, got, edge_n);
    endtask

    // Random stall spans of 1 to STALL_MAX cycles, each followed by a free cycle
    always @(negedge clk)
    begin
        if (!stall_on)
            stall = 1'b0;
        else if (stall_left > 0)
        begin
            stall = 1'b1;
            stall_left--;
        end
        else if (!stall && (($random(seed) & 3) == 0))
        begin
            stall      = 1'b1;
            stall_left = {$random(seed)} % STALL_MAX;
        end
        else
            stall = 1'b0;
    end

    // Output checker, samples the values held before each rising edge
    always @(posedge clk)
    begin
        if (!rst && stall)
        begin
            assert (!wb_valid) else
            begin
                pulse_errs++;
                $display("Write-back pulse seen during a stall at cycle %0d", cycles);
            end
            assert (!br_valid) else
            begin
                pulse_errs++;
                $display("Branch pulse seen during a stall at cycle %0d", cycles);
            end
        end
        else if (!rst)
        begin
            edge_n  = adv + 1;
            wb_head = (wb_q.size() > 0) ? wb_q[0] : '0;
            br_head = (br_q.size() > 0) ? br_q[0] : '0;
            exp_wb  = (wb_q.size() > 0) && (wb_head.due == edge_n);
            exp_br  = (br_q.size() > 0) && (br_head.due == edge_n);
            assert (wb_valid == exp_wb) else
            begin
                pulse_errs++;
                $display("Write-back pulse %s at edge %0d",
                         exp_wb ? "missing" : "not expected", edge_n);
            end
            assert (br_valid == exp_br) else
            begin
                pulse_errs++;
                $display("Branch pulse %s at edge %0d",
                         exp_br ? "missing" : "not expected", edge_n);
            end
            if (exp_wb && wb_valid)
            begin
                assert (wb_rd == wb_head.rd) else report_value("wb_rd", wb_head.rd, wb_rd);
                assert (wb_data == wb_head.data) else report_value("wb_data", wb_head.data, wb_data);
            end
            if (exp_br && br_valid)
            begin
                assert (br_taken == br_head.taken) else
                    report_value("br_taken", br_head.taken, br_taken);
                assert (br_target == br_head.target) else
                    report_value("br_target", br_head.target, br_target);
            end
            if (exp_wb)
                wb_q.delete(0);
            if (exp_br)
                br_q.delete(0);
            adv = edge_n;
        end
    end

    // Watchdog
    always @(posedge clk)
    begin
        cycles++;
        if (cycles >= LIMIT)
        begin
            $display("Timeout after %0d cycles with events still pending", cycles);
            $display("Errors: %0d value, %0d pulse, %0d total", val_errs, pulse_errs,
                     val_errs + pulse_errs);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    initial
    begin
        seed        = 6;
        rst         = 1'b1;
        stall       = 1'b0;
        stall_on    = 1'b0;
        stall_left  = 0;
        instr_valid = 1'b0;
        instr       = `RV_NOP;
        pc          = 32'd0;
        pc_r        = 32'h0000_1000;
        adv         = 0;
        cycles      = 0;
        val_errs    = 0;
        pulse_errs  = 0;
        for (int i = 0; i < `RV_NREGS; i++)
            rf[i] = 32'd0;
        pa      = '{32'd5, 32'hFFFF_FFFD, 32'd2, 32'd100};          // Equal, signed less
        pb      = '{32'd5, 32'd2, 32'hFFFF_FFF0, 32'd7};            // Unsigned less, greater
        imm_set = '{12'h800, 12'hFFF, 12'h000, 12'h001, 12'h7FF, 12'h5A3};
        repeat (RST_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // Register-register operations on random operands
        for (int r = 0; r < 4; r++)
        begin
            load(5'd1, $random(seed));
            load(5'd2, $random(seed));
            for (int f = 0; f < 8; f++)
                do_rr(f, 1'b0, 3 + f, 5'd1, 5'd2);
            do_rr(3'd0, 1'b1, 5'd11, 5'd1, 5'd2);   // SUB
            do_rr(3'd5, 1'b1, 5'd12, 5'd1, 5'd2);   // SRA
        end

        // Immediate forms, boundary and negative values
        load(5'd4, $random(seed));
        for (int k = 0; k < 6; k++)
            for (int f = 0; f < 8; f++)
                if (f != 1 && f != 5)
                    do_imm(f, 5'd5, 5'd4, imm_set[k]);
        load(5'd4, 32'h8765_4321);                  // Negative for SRAI
        for (int s = 0; s < 32; s = s + 15)
        begin
            do_imm(3'd1, 5'd5, 5'd4, s);
            do_imm(3'd5, 5'd5, 5'd4, s);
            do_imm(3'd5, 5'd5, 5'd4, 12'h400 | s);
        end
        do_lui(5'd6, 20'hFFFFF);
        do_lui(5'd6, 20'h80000);
        do_lui(5'd6, $random(seed));
        do_auipc(5'd7, 20'h00001);
        do_auipc(5'd7, 20'hFFFFF);
        do_auipc(5'd7, $random(seed));

        // Six branch conditions over four operand pairs
        for (int p = 0; p < 4; p++)
        begin
            load(5'd1, pa[p]);
            load(5'd2, pb[p]);
            for (int f = 0; f < 8; f++)
            begin
                boff    = $random(seed);
                boff[0] = 1'b0;
                if (f != 2 && f != 3)
                    do_br(f, 5'd1, 5'd2, boff);
            end
        end

        // Jumps, link and target
        do_jal(5'd8, 21'h000800);
        do_jal(5'd9, 21'h1FFFF0);                   // Backward
        do_jal(5'd0, 21'h000010);                   // Branch pulse only
        load(5'd10, 32'h0000_2001);
        do_jalr(5'd11, 5'd10, 12'h004);
        do_jalr(5'd12, 5'd10, 12'hFFF);
        do_jalr(5'd10, 5'd10, 12'h010);

        // Writes to x0 are dropped, reads give zero
        do_imm(3'd0, 5'd0, 5'd1, 12'h005);
        do_rr(3'd0, 1'b0, 5'd0, 5'd1, 5'd2);
        do_lui(5'd0, 20'hABCDE);
        do_rr(3'd0, 1'b0, 5'd13, 5'd0, 5'd1);
        do_rr(3'd6, 1'b0, 5'd14, 5'd0, 5'd0);

        // Same kinds of work under random stalls
        stall_on = 1'b1;
        for (int r = 0; r < 3; r++)
        begin
            load(5'd1, $random(seed));
            load(5'd2, $random(seed));
            for (int f = 0; f < 8; f++)
                do_rr(f, $random(seed), 15 + f, 5'd1, 5'd2);
            do_br(3'd6, 5'd1, 5'd2, 13'h0040);
            do_jal(5'd23, 21'h1FFF00);
        end

        @(negedge clk);
        stall_on    = 1'b0;
        instr_valid = 1'b0;
        while (wb_q.size() != 0 || br_q.size() != 0)
            @(posedge clk);
        repeat (6) @(posedge clk);                  // Catch late stray pulses
        $display("Errors: %0d value, %0d pulse, %0d total", val_errs, pulse_errs,
                 val_errs + pulse_errs);
        if (val_errs + pulse_errs == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

// File: tb/tb_clock.sv
module tb_clock (
    output logic clk
);

    initial
    begin
        clk = 1'b0;
    end

    always #2 clk = ~clk; // Period of 4

endmodule

// File: verilog/rv_core_top.sv
module rv_core_top (
    input  logic        clk,
    input  logic        rst,
    input  logic        stall,       // Freezes the whole pipe
    input  logic        instr_valid,
    input  logic [31:0] instr,
    input  logic [31:0] pc,          // PC of instr
    output logic        wb_valid,
    output logic [4:0]  wb_rd,
    output logic [31:0] wb_data,
    output logic        br_valid,
    output logic        br_taken,
    output logic [31:0] br_target
);

    dec_ex_if dx_bus ();
    ex_res_if xr_bus ();

    decode_stage u_dec (
        .clk         (clk),
        .rst         (rst),
        .stall       (stall),
        .instr_valid (instr_valid),
        .instr       (instr),
        .pc          (pc),
        .wb_valid    (wb_valid),    // Write-back loops to the register file
        .wb_rd       (wb_rd),
        .wb_data     (wb_data),
        .dx          (dx_bus.dec)
    );

    execute_stage u_ex (
        .clk       (clk),
        .rst       (rst),
        .stall     (stall),
        .dx        (dx_bus.ex),
        .xr        (xr_bus.ex),
        .br_valid  (br_valid),
        .br_taken  (br_taken),
        .br_target (br_target)
    );

    result_stage u_res (
        .clk      (clk),
        .rst      (rst),
        .stall    (stall),
        .xr       (xr_bus.res),
        .wb_valid (wb_valid),
        .wb_rd    (wb_rd),
        .wb_data  (wb_data)
    );

endmodule

// File: verilog/result_stage.sv
module result_stage (
    input  logic        clk,
    input  logic        rst,
    input  logic        stall,
    ex_res_if.res       xr,
    output logic        wb_valid,   // Also the register file write enable
    output logic [4:0]  wb_rd,
    output logic [31:0] wb_data
);
    import pipe_pkg::*;

    logic [31:0] wb_val;
    logic        wb_valid_q;

    assign wb_val = (xr.wb_sel == WB_LINK) ? xr.link : xr.alu_result;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            wb_valid_q <= 1'b0;
            wb_rd      <= 5'd0;
            wb_data    <= 32'd0;
        end
        else if (!stall)
        begin
            wb_valid_q <= xr.valid && xr.reg_write && (xr.rd != 5'd0); // Drop x0 writes
            wb_rd      <= xr.rd;
            wb_data    <= wb_val;
        end
    end

    // Pending write commits at the first edge without stall
    assign wb_valid = wb_valid_q && !stall;

endmodule

// File: verilog/execute_stage.sv
module execute_stage (
    input  logic        clk,
    input  logic        rst,
    input  logic        stall,
    dec_ex_if.ex        dx,
    ex_res_if.ex        xr,
    output logic        br_valid,   // One pulse per branch or jump
    output logic        br_taken,
    output logic [31:0] br_target
);
    import pipe_pkg::*;

    logic [31:0] op_a;
    logic [31:0] op_b;
    logic [31:0] alu_y;
    logic [31:0] target;
    logic [31:0] link;
    alu_op_e     op;
    logic        eq;
    logic        lt;
    logic        ltu;
    logic        cond;        // Branch condition met
    logic        taken;
    logic        is_ctl;      // Any control transfer
    logic        br_valid_q;

    // Operand A, branches always compare rs1
    always_comb
    begin
        if (dx.ctrl.is_branch)
            op_a = dx.rs1_val;
        else
        begin
            case (dx.ctrl.a_sel)
                A_PC:    op_a = dx.pc;
                A_ZERO:  op_a = 32'd0;
                default: op_a = dx.rs1_val;
            endcase
        end
    end

    assign op_b = (dx.ctrl.b_sel == B_IMM && !dx.ctrl.is_branch) ? dx.imm : dx.rs2_val;
    assign op   = dx.ctrl.is_branch ? ALU_SUB : dx.ctrl.alu_op;

    alu u_alu (
        .op  (op),
        .a   (op_a),
        .b   (op_b),
        .y   (alu_y),
        .eq  (eq),
        .lt  (lt),
        .ltu (ltu)
    );

    always_comb
    begin
        case (dx.ctrl.funct3)
            3'b000:  cond = eq;     // BEQ
            3'b001:  cond = !eq;    // BNE
            3'b100:  cond = lt;     // BLT
            3'b101:  cond = !lt;    // BGE
            3'b110:  cond = ltu;    // BLTU
            3'b111:  cond = !ltu;   // BGEU
            default: cond = 1'b0;
        endcase
    end

    // JALR target comes from the ALU sum with bit 0 cleared
    assign target = dx.ctrl.is_jalr ? {alu_y[31:1], 1'b0} : dx.pc + dx.imm;
    assign link   = dx.pc + 32'd4;
    assign taken  = dx.ctrl.is_jal || dx.ctrl.is_jalr || (dx.ctrl.is_branch && cond);
    assign is_ctl = dx.ctrl.is_branch || dx.ctrl.is_jal || dx.ctrl.is_jalr;

    // Execute/result register and branch outputs
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            xr.valid      <= 1'b0;
            xr.reg_write  <= 1'b0;
            xr.wb_sel     <= WB_ALU;
            xr.rd         <= 5'd0;
            xr.alu_result <= 32'd0;
            xr.link       <= 32'd0;
            br_valid_q    <= 1'b0;
            br_taken      <= 1'b0;
            br_target     <= 32'd0;
        end
        else if (!stall)
        begin
            xr.valid      <= dx.valid;
            xr.reg_write  <= dx.valid && dx.ctrl.reg_write;
            xr.wb_sel     <= dx.ctrl.wb_sel;
            xr.rd         <= dx.rd;
            xr.alu_result <= alu_y;
            xr.link       <= link;
            br_valid_q    <= dx.valid && is_ctl;
            br_taken      <= taken;
            br_target     <= target;
        end
    end

    assign br_valid = br_valid_q && !stall; // Held entry shows once stall drops

endmodule

// File: verilog/alu.sv
module alu (
    input  pipe_pkg::alu_op_e op,
    input  logic [31:0]       a,
    input  logic [31:0]       b,
    output logic [31:0]       y,
    output logic              eq,   // a == b
    output logic              lt,   // Signed a < b
    output logic              ltu   // Unsigned a < b
);
    import pipe_pkg::*;

    logic [4:0] shamt;

    assign shamt = b[4:0];           // Only low five bits shift

    // Flags independent of op, branch logic relies on this
    assign eq  = (a == b);
    assign lt  = ($signed(a) < $signed(b));
    assign ltu = (a < b);

    always_comb
    begin
        case (op)
            ALU_ADD:  y = a + b;
            ALU_SUB:  y = a - b;
            ALU_SLL:  y = a << shamt;
            ALU_SLT:  y = {31'd0, lt};
            ALU_SLTU: y = {31'd0, ltu};
            ALU_XOR:  y = a ^ b;
            ALU_SRL:  y = a >> shamt;
            ALU_SRA:  y = $unsigned($signed(a) >>> shamt); // Arithmetic shift keeps sign
            ALU_OR:   y = a | b;
            ALU_AND:  y = a & b;
            default:  y = 32'd0;
        endcase
    end

endmodule

// File: verilog/decode_stage.sv
`include "rv_defs.svh"

module decode_stage (
    input  logic            clk,
    input  logic            rst,
    input  logic            stall,
    input  logic            instr_valid,
    input  isa_pkg::instr_u instr,
    input  logic [31:0]     pc,
    input  logic            wb_valid,    // Write-back from result stage
    input  logic [4:0]      wb_rd,
    input  logic [31:0]     wb_data,
    dec_ex_if.dec           dx
);
    import isa_pkg::*;
    import pipe_pkg::*;

    logic [31:0] rs1_val;
    logic [31:0] rs2_val;
    logic [31:0] imm;
    logic [31:0] imm_i;
    logic [31:0] imm_b;
    logic [31:0] imm_u;
    logic [31:0] imm_j;
    ctrl_t       ctrl;
    logic        known;      // Opcode and funct3 recognized

    // Funct3 to ALU op, sub_ok false for immediates where bit 30 is part of imm
    function automatic alu_op_e alu_decode(input logic [2:0] f3, input logic alt,
                                           input logic sub_ok);
        case (f3)
            3'b000:  return (alt && sub_ok) ? ALU_SUB : ALU_ADD;
            3'b001:  return ALU_SLL;
            3'b010:  return ALU_SLT;
            3'b011:  return ALU_SLTU;
            3'b100:  return ALU_XOR;
            3'b101:  return alt ? ALU_SRA : ALU_SRL; // SRAI also uses bit 30
            3'b110:  return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    reg_file u_rf (
        .clk    (clk),
        .rst    (rst),
        .we     (wb_valid),
        .waddr  (wb_rd),
        .wdata  (wb_data),
        .raddr1 (instr.r.rs1),
        .raddr2 (instr.r.rs2),
        .rdata1 (rs1_val),
        .rdata2 (rs2_val)
    );

    // Immediates from each format view
    assign imm_i = {{20{instr.i.imm[11]}}, instr.i.imm};
    assign imm_b = {{19{instr.b.imm12}}, instr.b.imm12, instr.b.imm11,
                    instr.b.imm10_5, instr.b.imm4_1, 1'b0};
    assign imm_u = {instr.u.imm, 12'd0};
    assign imm_j = {{11{instr.j.imm20}}, instr.j.imm20, instr.j.imm19_12,
                    instr.j.imm11, instr.j.imm10_1, 1'b0};

    always_comb
    begin
        ctrl           = '0;
        ctrl.alu_op    = ALU_ADD;
        ctrl.a_sel     = A_RS1;
        ctrl.b_sel     = B_RS2;
        ctrl.wb_sel    = WB_ALU;
        ctrl.funct3    = instr.r.funct3;
        imm            = 32'd0;
        known          = 1'b1;
        case (instr.r.opcode)
            OPC_OP:
            begin
                ctrl.alu_op    = alu_decode(instr.r.funct3, instr.r.funct7[5], 1'b1);
                ctrl.reg_write = 1'b1;
            end
            OPC_OP_IMM:
            begin
                ctrl.alu_op    = alu_decode(instr.r.funct3, instr.r.funct7[5], 1'b0);
                ctrl.b_sel     = B_IMM;
                ctrl.reg_write = 1'b1;
                imm            = imm_i;
            end
            OPC_LUI:
            begin
                ctrl.a_sel     = A_ZERO;  // 0 + imm
                ctrl.b_sel     = B_IMM;
                ctrl.reg_write = 1'b1;
                imm            = imm_u;
            end
            OPC_AUIPC:
            begin
                ctrl.a_sel     = A_PC;    // PC + imm
                ctrl.b_sel     = B_IMM;
                ctrl.reg_write = 1'b1;
                imm            = imm_u;
            end
            OPC_BRANCH:
            begin
                ctrl.alu_op    = ALU_SUB;
                ctrl.is_branch = 1'b1;
                imm            = imm_b;
                known          = (instr.r.funct3[2:1] != 2'b01); // 010 and 011 are reserved
            end
            OPC_JAL:
            begin
                ctrl.is_jal    = 1'b1;
                ctrl.wb_sel    = WB_LINK;
                ctrl.reg_write = 1'b1;
                imm            = imm_j;
            end
            OPC_JALR:
            begin
                ctrl.is_jalr   = 1'b1;
                ctrl.b_sel     = B_IMM;   // ALU forms rs1 + imm for the target
                ctrl.wb_sel    = WB_LINK;
                ctrl.reg_write = 1'b1;
                imm            = imm_i;
            end
            default:
            begin
                known = 1'b0;             // Unsupported opcode becomes a bubble
            end
        endcase
    end

    // Decode/execute register
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            dx.valid   <= 1'b0;
            dx.ctrl    <= '0;
            dx.rs1_val <= 32'd0;
            dx.rs2_val <= 32'd0;
            dx.imm     <= 32'd0;
            dx.pc      <= 32'd0;
            dx.rd      <= 5'd0;
        end
        else if (!stall)
        begin
            dx.valid   <= instr_valid && known && (instr != `RV_NOP); // NOP has no effect
            dx.ctrl    <= ctrl;
            dx.rs1_val <= rs1_val;
            dx.rs2_val <= rs2_val;
            dx.imm     <= imm;
            dx.pc      <= pc;
            dx.rd      <= instr.r.rd;
        end
    end

endmodule

// File: verilog/reg_file.sv
`include "rv_defs.svh"

module reg_file (
    input  logic        clk,
    input  logic        rst,
    input  logic        we,     // Write enable, already stall qualified
    input  logic [4:0]  waddr,
    input  logic [31:0] wdata,
    input  logic [4:0]  raddr1,
    input  logic [4:0]  raddr2,
    output logic [31:0] rdata1,
    output logic [31:0] rdata2
);

    logic [31:0] regs [`RV_NREGS];

    // Read with write-through so a same-edge write is seen
    function automatic logic [31:0] read_port(input logic [4:0] addr);
        if (addr == 5'd0)
            return 32'd0;                 // x0 is hardwired
        else if (we && (addr == waddr))
            return wdata;                 // Bypass the pending write
        else
            return regs[addr];
    endfunction

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            for (int i = 0; i < `RV_NREGS; i++)
                regs[i] <= 32'd0;
        end
        else if (we && (waddr != 5'd0))   // x0 ignores writes
        begin
            regs[waddr] <= wdata;
        end
    end

    always_comb
    begin
        rdata1 = read_port(raddr1);
        rdata2 = read_port(raddr2);
    end

endmodule

// File: verilog/pipe_if.sv
// Decode to execute stage register contents
interface dec_ex_if;
    import pipe_pkg::*;

    logic        valid;   // Live instruction, not a bubble
    ctrl_t       ctrl;
    logic [31:0] rs1_val;
    logic [31:0] rs2_val;
    logic [31:0] imm;     // Already sign extended
    logic [31:0] pc;
    logic [4:0]  rd;

    modport dec (
        output valid, ctrl, rs1_val, rs2_val, imm, pc, rd
    );

    modport ex (
        input valid, ctrl, rs1_val, rs2_val, imm, pc, rd
    );

endinterface

// Execute to result stage register contents
interface ex_res_if;
    import pipe_pkg::*;

    logic        valid;
    logic        reg_write;  // Already qualified with valid
    wb_sel_e     wb_sel;
    logic [4:0]  rd;
    logic [31:0] alu_result;
    logic [31:0] link;       // PC+4

    modport ex (
        output valid, reg_write, wb_sel, rd, alu_result, link
    );

    modport res (
        input valid, reg_write, wb_sel, rd, alu_result, link
    );

endinterface

// File: verilog/pipe_pkg.sv
package pipe_pkg;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,  // Also used for branch compares
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_e;

    typedef enum logic [1:0] {
        A_RS1,  // Normal register operand
        A_PC,   // AUIPC
        A_ZERO  // LUI
    } a_sel_e;

    typedef enum logic {
        B_RS2,
        B_IMM
    } b_sel_e;

    typedef enum logic {
        WB_ALU,  // ALU result
        WB_LINK  // PC+4 for JAL and JALR
    } wb_sel_e;

    // Decoded control carried down the pipe
    typedef struct packed {
        alu_op_e    alu_op;
        a_sel_e     a_sel;
        b_sel_e     b_sel;
        wb_sel_e    wb_sel;
        logic       reg_write; // Instruction writes rd
        logic       is_branch;
        logic       is_jal;
        logic       is_jalr;
        logic [2:0] funct3;    // Branch condition select
    } ctrl_t;

endpackage

// File: verilog/isa_pkg.sv
`include "rv_defs.svh"

package isa_pkg;

    typedef enum logic [6:0] {
        OPC_OP     = `RV_OP_OP,     // R-type arithmetic
        OPC_OP_IMM = `RV_OP_OP_IMM, // I-type arithmetic
        OPC_LUI    = `RV_OP_LUI,
        OPC_AUIPC  = `RV_OP_AUIPC,
        OPC_BRANCH = `RV_OP_BRANCH, // B-type
        OPC_JAL    = `RV_OP_JAL,    // J-type
        OPC_JALR   = `RV_OP_JALR    // I-type layout
    } opcode_e;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        opcode_e    opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm; // Sign bit is imm[11]
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        opcode_e     opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi; // imm[11:5]
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo; // imm[4:0]
        opcode_e    opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm12;    // Sign bit
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        opcode_e    opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm; // imm[31:12]
        logic [4:0]  rd;
        opcode_e     opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm20;    // Sign bit
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        opcode_e    opcode;
    } j_fmt_t;

    // One instruction word seen through every format
    typedef union packed {
        r_fmt_t r; // Register fields and opcode live here
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
        u_fmt_t u;
        j_fmt_t j;
    } instr_u;

endpackage

// File: include/rv_defs.svh
`ifndef RV_DEFS_SVH
`define RV_DEFS_SVH

// Architectural register count of RV32I
`define RV_NREGS 32

// Major opcodes handled by the core
`define RV_OP_OP     7'b0110011 // Register-register ALU
`define RV_OP_OP_IMM 7'b0010011 // Register-immediate ALU
`define RV_OP_LUI    7'b0110111 // Load upper immediate
`define RV_OP_AUIPC  7'b0010111 // Add upper immediate to PC
`define RV_OP_BRANCH 7'b1100011 // Conditional branches
`define RV_OP_JAL    7'b1101111 // Jump and link
`define RV_OP_JALR   7'b1100111 // Jump and link register

// Canonical NOP, addi x0,x0,0
`define RV_NOP 32'h0000_0013

`endif
